//--- hw/muldiv_macros.svh
`ifndef MULDIV_MACROS_SVH
`define MULDIV_MACROS_SVH

// ==================================================
// datapath sizing
// ==================================================

`define MD_XLEN 32

// rename register id width
`define MD_RNID_W 6

// reservation station slots and one-hot index width
`define MD_RV_ENTRY_SIZE 16

// multiplier bits retired per pipeline stage (4, 8 or 16)
`define MD_MUL_UNROLL 8

`endif

//--- hw/muldiv_pkg.sv
`include "muldiv_macros.svh"

package muldiv_pkg;

  // ==================================================
  // opcodes and register classes
  // ==================================================

  // same order as the M-extension funct3 field
  typedef enum logic [2:0] {
    MUL    = 3'd0,
    MULH   = 3'd1,
    MULHSU = 3'd2,
    MULHU  = 3'd3,
    DIV    = 3'd4,
    DIVU   = 3'd5,
    REM    = 3'd6,
    REMU   = 3'd7
  } md_op_t;

  typedef enum logic {
    GPR = 1'b0,
    FPR = 1'b1
  } md_reg_t;

  // ==================================================
  // tag and result channel
  // ==================================================

  typedef struct packed {
    logic [`MD_RNID_W-1:0]        rd_rnid;
    md_reg_t                      rd_type;
    logic [`MD_RV_ENTRY_SIZE-1:0] index_oh;  // one-hot rs slot
  } md_tag_t;

  typedef struct packed {
    logic                valid;
    logic [`MD_XLEN-1:0] res;
    md_tag_t             tag;
  } md_res_t;

  // ==================================================
  // divider FSM
  // ==================================================

  typedef enum logic [1:0] {
    IDLE = 2'd0,
    RUN  = 2'd1,  // shift-subtract steps and fix-up after the load
    DONE = 2'd2   // result held until granted
  } md_div_state_t;

endpackage

//--- hw/mul_pipe.sv
`include "muldiv_macros.svh"

module mul_pipe
  import muldiv_pkg::*;
#(
  parameter int MUL_UNROLL = `MD_MUL_UNROLL
) (
  input  logic                i_clk,
  input  logic                i_reset_n,
  input  logic                i_start,
  input  md_op_t              i_op,
  input  md_tag_t             i_tag,
  input  logic [`MD_XLEN-1:0] i_rs1,
  input  logic [`MD_XLEN-1:0] i_rs2,
  output logic                o_valid,
  output logic [`MD_XLEN-1:0] o_res,
  output md_tag_t             o_tag
);

  localparam int XLEN     = `MD_XLEN;
  localparam int MUL_STEP = (XLEN + MUL_UNROLL - 1) / MUL_UNROLL;
  localparam int PROD_W   = 2 * XLEN + 2;  // full 33 x 33 product
  localparam int PART_W   = XLEN + MUL_UNROLL + 2;

  typedef struct packed {
    md_op_t            op;
    md_tag_t           tag;
    logic [XLEN:0]     mplier;  // extended rs1
    logic [XLEN:0]     mcand;   // extended rs2
    logic [PROD_W-1:0] acc;     // running partial product
  } mul_stage_t;

  logic       w_rs1_signed;
  logic       w_rs2_signed;
  mul_stage_t w_in;

  logic [MUL_STEP:1] r_valid;
  mul_stage_t        r_stage [1:MUL_STEP];
  mul_stage_t        w_next  [0:MUL_STEP-1];
  mul_stage_t        w_last;

  // ==================================================
  // operand extension
  // ==================================================

  assign w_rs1_signed = (i_op == MUL) || (i_op == MULH) || (i_op == MULHSU);
  assign w_rs2_signed = (i_op == MUL) || (i_op == MULH);

  assign w_in = '{
    op:     i_op,
    tag:    i_tag,
    mplier: {w_rs1_signed & i_rs1[XLEN-1], i_rs1},
    mcand:  {w_rs2_signed & i_rs2[XLEN-1], i_rs2},
    acc:    '0
  };

  // ==================================================
  // one multiplier group per stage
  // ==================================================

  for (genvar s = 0; s < MUL_STEP; s++) begin : g_stage
    mul_stage_t                 w_cur;
    logic [MUL_UNROLL-1:0]      w_group;
    logic                       w_top;
    logic signed [MUL_UNROLL:0] w_digit;
    logic signed [XLEN:0]       w_mcand;
    logic signed [PART_W-1:0]   w_part;
    logic [PROD_W-1:0]          w_acc;

    if (s == 0) begin : g_first
      assign w_cur = w_in;
    end else begin : g_later
      assign w_cur = r_stage[s];
    end

    // sign bit of rs1 rides on the top group with negative weight
    assign w_top   = (s == MUL_STEP - 1) ? w_cur.mplier[XLEN] : 1'b0;
    assign w_group = w_cur.mplier[MUL_UNROLL*s +: MUL_UNROLL];
    assign w_digit = {w_top, w_group};
    assign w_mcand = w_cur.mcand;
    assign w_part  = PART_W'(w_digit) * PART_W'(w_mcand);
    assign w_acc   = w_cur.acc + (PROD_W'(w_part) << (MUL_UNROLL * s));

    assign w_next[s] = '{
      op:     w_cur.op,
      tag:    w_cur.tag,
      mplier: w_cur.mplier,
      mcand:  w_cur.mcand,
      acc:    w_acc
    };
  end

  // ==================================================
  // pipeline registers
  // ==================================================

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid <= '0;
    end else begin
      r_valid <= {r_valid[MUL_STEP-1:1], i_start};
    end
  end

  always_ff @(posedge i_clk) begin
    for (int s = 0; s < MUL_STEP; s++) begin
      r_stage[s+1] <= w_next[s];
    end
  end

  assign w_last = r_stage[MUL_STEP];

  assign o_valid = r_valid[MUL_STEP];
  assign o_tag   = w_last.tag;
  assign o_res   = (w_last.op == MUL) ? w_last.acc[XLEN-1:0]     // low half
                                      : w_last.acc[2*XLEN-1:XLEN];

endmodule

//--- hw/div_unit.sv
`include "muldiv_macros.svh"

module div_unit
  import muldiv_pkg::*;
(
  input  logic                i_clk,
  input  logic                i_reset_n,
  input  logic                i_start,
  input  md_op_t              i_op,
  input  md_tag_t             i_tag,
  input  logic [`MD_XLEN-1:0] i_rs1,
  input  logic [`MD_XLEN-1:0] i_rs2,
  input  logic                i_grant,
  output logic                o_busy,
  output logic                o_valid,
  output logic [`MD_XLEN-1:0] o_res,
  output md_tag_t             o_tag
);

  localparam int XLEN  = `MD_XLEN;
  localparam int CNT_W = $clog2(XLEN + 1);

  typedef struct packed {
    md_op_t          op;
    md_tag_t         tag;
    logic [XLEN-1:0] dividend;  // raw rs1
    logic            neg_q;
    logic            neg_r;
    logic            by_zero;
    logic            ovf;
  } div_ctx_t;

  md_div_state_t r_state;
  logic [CNT_W-1:0] r_cnt;

  div_ctx_t        r_ctx;
  logic [XLEN-1:0] r_divisor;
  logic [XLEN-1:0] r_quot;  // quotient shifts in as the dividend shifts out
  logic [XLEN-1:0] r_rem;
  logic [XLEN-1:0] r_res;

  logic            w_signed;
  logic            w_rs1_neg;
  logic            w_rs2_neg;
  logic [XLEN-1:0] w_rs1_mag;
  logic [XLEN-1:0] w_rs2_mag;
  div_ctx_t        w_ctx;

  logic            w_load;
  logic            w_last;
  logic [XLEN:0]   w_shift;
  logic [XLEN+1:0] w_diff;
  logic            w_ge;

  logic [XLEN-1:0] w_quot_fix;
  logic [XLEN-1:0] w_rem_fix;
  logic [XLEN-1:0] w_q;
  logic [XLEN-1:0] w_r;
  logic [XLEN-1:0] w_res_fix;

  // ==================================================
  // operand load
  // ==================================================

  assign w_signed  = (i_op == DIV) || (i_op == REM);
  assign w_rs1_neg = w_signed & i_rs1[XLEN-1];
  assign w_rs2_neg = w_signed & i_rs2[XLEN-1];
  assign w_rs1_mag = w_rs1_neg ? -i_rs1 : i_rs1;
  assign w_rs2_mag = w_rs2_neg ? -i_rs2 : i_rs2;

  assign w_ctx = '{
    op:       i_op,
    tag:      i_tag,
    dividend: i_rs1,
    neg_q:    w_rs1_neg ^ w_rs2_neg,
    neg_r:    w_rs1_neg,  // remainder follows the dividend
    by_zero:  (i_rs2 == '0),
    ovf:      w_signed && (i_rs1 == {1'b1, {(XLEN-1){1'b0}}}) && (i_rs2 == '1)
  };

  assign w_load = (r_state == IDLE) && i_start;
  assign w_last = (r_state == RUN) && (r_cnt == CNT_W'(XLEN));

  // ==================================================
  // restoring step
  // ==================================================

  assign w_shift = {r_rem, r_quot[XLEN-1]};
  assign w_diff  = {1'b0, w_shift} - {2'b00, r_divisor};
  assign w_ge    = ~w_diff[XLEN+1];  // no borrow

  // ==================================================
  // fix-up
  // ==================================================

  assign w_quot_fix = r_ctx.neg_q ? -r_quot : r_quot;
  assign w_rem_fix  = r_ctx.neg_r ? -r_rem : r_rem;

  always_comb begin
    w_q = w_quot_fix;
    w_r = w_rem_fix;
    if (r_ctx.by_zero) begin
      w_q = '1;
      w_r = r_ctx.dividend;
    end else if (r_ctx.ovf) begin
      w_q = r_ctx.dividend;  // min / -1
      w_r = '0;
    end
    w_res_fix = ((r_ctx.op == DIV) || (r_ctx.op == DIVU)) ? w_q : w_r;
  end

  // ==================================================
  // FSM
  // ==================================================

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state <= IDLE;
      r_cnt   <= '0;
    end else begin
      case (r_state)
        IDLE: begin
          if (i_start) begin
            r_state <= RUN;
            r_cnt   <= '0;
          end
        end
        RUN: begin
          r_cnt <= r_cnt + 1'b1;
          if (w_last) begin
            r_state <= DONE;
          end
        end
        DONE: begin
          if (i_grant) begin
            r_state <= IDLE;  // port was ours this cycle
          end
        end
        default: r_state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_load) begin
      r_ctx     <= w_ctx;
      r_divisor <= w_rs2_mag;
      r_quot    <= w_rs1_mag;
      r_rem     <= '0;
    end else if (w_last) begin
      r_res <= w_res_fix;
    end else if (r_state == RUN) begin
      r_quot <= {r_quot[XLEN-2:0], w_ge};
      r_rem  <= w_ge ? w_diff[XLEN-1:0] : w_shift[XLEN-1:0];
    end
  end

  assign o_busy  = (r_state != IDLE);
  assign o_valid = (r_state == DONE) && i_grant;
  assign o_res   = r_res;
  assign o_tag   = r_ctx.tag;

endmodule

//--- hw/muldiv_pipe.sv
`include "muldiv_macros.svh"

module muldiv_pipe
  import muldiv_pkg::*;
(
  input  logic                i_clk,
  input  logic                i_reset_n,
  input  logic                i_valid,
  input  md_op_t              i_op,
  input  md_tag_t             i_tag,
  input  logic [`MD_XLEN-1:0] i_rs1,
  input  logic [`MD_XLEN-1:0] i_rs2,
  output logic                o_stall,
  output logic                o_valid,
  output logic [`MD_XLEN-1:0] o_res,
  output md_tag_t             o_tag
);

  logic w_is_div;
  logic w_accept;
  logic w_mul_start;
  logic w_div_start;

  logic                w_mul_valid;
  logic [`MD_XLEN-1:0] w_mul_res;
  md_tag_t             w_mul_tag;

  logic                w_div_busy;
  logic                w_div_grant;
  logic                w_div_valid;
  logic [`MD_XLEN-1:0] w_div_res;
  md_tag_t             w_div_tag;

  md_res_t w_mul_ch;
  md_res_t w_div_ch;
  md_res_t w_out;

  // ==================================================
  // dispatch
  // ==================================================

  assign w_is_div    = i_op inside {DIV, DIVU, REM, REMU};
  assign w_accept    = i_valid & ~o_stall;  // dropped while stalled
  assign w_mul_start = w_accept & ~w_is_div;
  assign w_div_start = w_accept & w_is_div;

  mul_pipe #(
    .MUL_UNROLL (`MD_MUL_UNROLL)
  ) u_mul_pipe (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_start   (w_mul_start),
    .i_op      (i_op),
    .i_tag     (i_tag),
    .i_rs1     (i_rs1),
    .i_rs2     (i_rs2),
    .o_valid   (w_mul_valid),
    .o_res     (w_mul_res),
    .o_tag     (w_mul_tag)
  );

  div_unit u_div_unit (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_start   (w_div_start),
    .i_op      (i_op),
    .i_tag     (i_tag),
    .i_rs1     (i_rs1),
    .i_rs2     (i_rs2),
    .i_grant   (w_div_grant),
    .o_busy    (w_div_busy),
    .o_valid   (w_div_valid),
    .o_res     (w_div_res),
    .o_tag     (w_div_tag)
  );

  // ==================================================
  // result port
  // ==================================================

  assign w_div_grant = ~w_mul_valid;  // multiplier has priority

  assign w_mul_ch = '{valid: w_mul_valid, res: w_mul_res, tag: w_mul_tag};
  assign w_div_ch = '{valid: w_div_valid, res: w_div_res, tag: w_div_tag};
  assign w_out    = w_div_ch.valid ? w_div_ch : w_mul_ch;

  assign o_valid = w_out.valid;
  assign o_res   = w_out.res;
  assign o_tag   = w_out.tag;
  assign o_stall = w_div_busy;

endmodule

//--- tests/muldiv_model.svh
`ifndef MULDIV_MODEL_SVH
`define MULDIV_MODEL_SVH

// ==================================================
// M-extension reference results
// ==================================================

// only the low 2*XLEN bits of the double-width product matter
function automatic logic [`MD_XLEN-1:0] mul_reference(
  input md_op_t              op,
  input logic [`MD_XLEN-1:0] a,
  input logic [`MD_XLEN-1:0] b
);
  logic [2*`MD_XLEN-1:0] wa;
  logic [2*`MD_XLEN-1:0] wb;
  logic [2*`MD_XLEN-1:0] prod;
  wa   = {{`MD_XLEN{a[`MD_XLEN-1] && (op != MULHU)}}, a};
  wb   = {{`MD_XLEN{b[`MD_XLEN-1] && ((op == MUL) || (op == MULH))}}, b};
  prod = wa * wb;
  return (op == MUL) ? prod[`MD_XLEN-1:0] : prod[2*`MD_XLEN-1:`MD_XLEN];
endfunction

function automatic logic [`MD_XLEN-1:0] div_reference(
  input md_op_t              op,
  input logic [`MD_XLEN-1:0] a,
  input logic [`MD_XLEN-1:0] b
);
  logic signed [`MD_XLEN-1:0] sa;
  logic signed [`MD_XLEN-1:0] sb;
  logic [`MD_XLEN-1:0]        q;
  logic [`MD_XLEN-1:0]        r;
  logic                       sgn;
  sa  = a;
  sb  = b;
  sgn = (op == DIV) || (op == REM);
  if (b == '0) begin
    q = '1;
    r = a;
  end else if (sgn && (a == {1'b1, {(`MD_XLEN-1){1'b0}}}) && (b == '1)) begin
    q = a;  // min / -1 wraps
    r = '0;
  end else if (sgn) begin
    q = sa / sb;  // truncates toward zero
    r = sa % sb;
  end else begin
    q = a / b;
    r = a % b;
  end
  return ((op == DIV) || (op == DIVU)) ? q : r;
endfunction

`endif

//--- tests/tb_muldiv.sv
`include "muldiv_macros.svh"

module tb_muldiv
  import muldiv_pkg::*;
();

  `include "muldiv_model.svh"

  localparam int XLEN     = `MD_XLEN;
  localparam int RNID_W   = `MD_RNID_W;
  localparam int N_SLOT   = `MD_RV_ENTRY_SIZE;
  localparam int MUL_STEP = (XLEN + `MD_MUL_UNROLL - 1) / `MD_MUL_UNROLL;
  localparam int DIV_LAT  = XLEN + 2;
  localparam int N_CORNER = 16;
  localparam int N_ROWS   = N_CORNER + 24;

  typedef struct packed {
    md_op_t          op;
    logic [XLEN-1:0] rs1;
    logic [XLEN-1:0] rs2;
    logic            b2b;  // issue right after the previous row
  } row_t;

  logic            i_clk;
  logic            i_reset_n;
  logic            i_valid;
  md_op_t          i_op;
  md_tag_t         i_tag;
  logic [XLEN-1:0] i_rs1;
  logic [XLEN-1:0] i_rs2;
  logic            o_stall;
  logic            o_valid;
  logic [XLEN-1:0] o_res;
  md_tag_t         o_tag;

  row_t corner [N_CORNER] = '{
    '{MUL,    32'h0000_0000, 32'h1234_5678, 1'b0},
    '{MULH,   32'hffff_ffff, 32'hffff_ffff, 1'b1},
    '{MULHSU, 32'h8000_0000, 32'hffff_ffff, 1'b1},
    '{MULHU,  32'hffff_ffff, 32'hffff_ffff, 1'b1},
    '{MULH,   32'h8000_0000, 32'h8000_0000, 1'b1},
    '{MUL,    32'h7fff_ffff, 32'h7fff_ffff, 1'b1},
    '{MULHSU, 32'hffff_ffff, 32'h8000_0000, 1'b1},
    '{DIV,    32'h8000_0000, 32'hffff_ffff, 1'b1},  // muls still in flight
    '{DIVU,   32'h1234_5678, 32'h0000_0000, 1'b0},
    '{REM,    32'h8000_0000, 32'hffff_ffff, 1'b0},
    '{REMU,   32'h1234_5678, 32'h0000_0000, 1'b0},
    '{DIV,    32'hffff_ff9c, 32'h0000_0007, 1'b0},
    '{REM,    32'hffff_ff9c, 32'h0000_0007, 1'b0},
    '{DIV,    32'h7fff_ffff, 32'h0000_0000, 1'b0},
    '{MULHU,  32'h7fff_ffff, 32'h8000_0000, 1'b0},
    '{DIVU,   32'hffff_ffff, 32'h0000_0001, 1'b1}
  };

  row_t            tbl        [N_ROWS];
  logic [XLEN-1:0] exp_res    [N_ROWS];
  md_tag_t         exp_tag    [N_ROWS];
  logic            issued     [N_ROWS];
  int              accept_cyc [N_ROWS];  // edge that samples the request
  int              seen       [N_ROWS];
  int              cycle     = 0;
  int              last_div  = -1;
  int              mon_pass  = 0;
  int              mon_fail  = 0;
  int              main_fail = 0;

  muldiv_pipe dut (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_valid   (i_valid),
    .i_op      (i_op),
    .i_tag     (i_tag),
    .i_rs1     (i_rs1),
    .i_rs2     (i_rs2),
    .o_stall   (o_stall),
    .o_valid   (o_valid),
    .o_res     (o_res),
    .o_tag     (o_tag)
  );

  always #4 i_clk = ~i_clk;

  always @(posedge i_clk) begin
    cycle <= cycle + 1;
  end

  function automatic logic is_divide(input md_op_t op);
    return op inside {DIV, DIVU, REM, REMU};
  endfunction

  function automatic int returned_count();
    int n;
    n = 0;
    for (int i = 0; i < N_ROWS; i++) begin
      n += seen[i];
    end
    return n;
  endfunction

  task automatic wait_stall_clear(input int row);
    int n;
    n = 0;
    @(negedge i_clk);
    while (o_stall && n < 100) begin
      @(negedge i_clk);
      n++;
    end
    if (o_stall) begin
      $display("timeout waiting for the stall to clear before row %0d", row);
      main_fail++;
    end
  endtask

  // ==================================================
  // scoreboard
  // ==================================================

  always @(posedge i_clk) begin : monitor
    int     id;
    int     lat;
    int     want;
    logic   ok;
    md_op_t op;
    if (last_div >= 0 && seen[last_div] == 0 && cycle > accept_cyc[last_div] && !o_stall) begin
      $display("stall low while the division of row %0d is outstanding", last_div);
      mon_fail++;
    end
    if (o_valid) begin
      id = int'(o_tag.rd_rnid);
      if (id >= N_ROWS || !issued[id]) begin
        $display("result arrived with a tag that was never issued, rnid %0d", id);
        mon_fail++;
      end else if (seen[id] != 0) begin
        $display("row %0d returned a second result", id);
        mon_fail++;
      end else begin
        seen[id] = 1;
        op       = tbl[id].op;
        ok       = 1'b1;
        if (o_res !== exp_res[id]) begin
          $display("FAILED row %0d o_res expected %h got %h", id, exp_res[id], o_res);
          ok = 1'b0;
        end
        if (o_tag !== exp_tag[id]) begin
          $display("FAILED row %0d o_tag expected %h got %h", id, exp_tag[id], o_tag);
          ok = 1'b0;
        end
        lat  = cycle - accept_cyc[id];
        want = is_divide(op) ? DIV_LAT : MUL_STEP;
        if (lat != want) begin
          $display("row %0d returned %0d cycles after issue instead of %0d", id, lat, want);
          ok = 1'b0;
        end
        if (ok) begin
          $display("row %0d %s %h %h -> %h ok", id, op.name(), tbl[id].rs1, tbl[id].rs2, o_res);
          mon_pass++;
        end else begin
          $display("row %0d %s %h %h failed", id, op.name(), tbl[id].rs1, tbl[id].rs2);
          mon_fail++;
        end
      end
    end
  end

  // ==================================================
  // stimulus
  // ==================================================

  initial begin : main
    int n;
    void'($urandom(32'h492b));
    i_clk     = 1'b0;
    i_reset_n = 1'b0;
    i_valid   = 1'b0;
    i_op      = MUL;
    i_tag     = '0;
    i_rs1     = '0;
    i_rs2     = '0;

    for (int i = 0; i < N_ROWS; i++) begin
      if (i < N_CORNER) begin
        tbl[i] = corner[i];
      end else begin
        tbl[i].op  = md_op_t'(3'($urandom_range(7, 0)));
        tbl[i].rs1 = $urandom;
        tbl[i].rs2 = $urandom >> $urandom_range(XLEN - 1, 0);  // spread divisor sizes
        tbl[i].b2b = 1'($urandom_range(1, 0));
      end
      exp_res[i]                      = is_divide(tbl[i].op) ?
                                        div_reference(tbl[i].op, tbl[i].rs1, tbl[i].rs2) :
                                        mul_reference(tbl[i].op, tbl[i].rs1, tbl[i].rs2);
      exp_tag[i].rd_rnid              = RNID_W'(i);
      exp_tag[i].rd_type              = md_reg_t'(1'($urandom_range(1, 0)));
      exp_tag[i].index_oh             = '0;
      exp_tag[i].index_oh[i % N_SLOT] = 1'b1;
      issued[i]                       = 1'b0;
    end

    repeat (4) @(posedge i_clk);
    i_reset_n <= 1'b1;
    @(negedge i_clk);
    if (o_valid !== 1'b0) begin
      $display("FAILED o_valid after reset expected %h got %h", 1'b0, o_valid);
      main_fail++;
    end
    if (o_stall !== 1'b0) begin
      $display("FAILED o_stall after reset expected %h got %h", 1'b0, o_stall);
      main_fail++;
    end

    // a request right behind a division meets the stall and is dropped
    for (int i = 0; i < N_ROWS; i++) begin
      if (i == 0 || !tbl[i].b2b || is_divide(tbl[i-1].op)) begin
        @(posedge i_clk);
        i_valid <= 1'b0;
        wait_stall_clear(i);
      end
      @(posedge i_clk);
      i_valid       <= 1'b1;
      i_op          <= tbl[i].op;
      i_rs1         <= tbl[i].rs1;
      i_rs2         <= tbl[i].rs2;
      i_tag         <= exp_tag[i];
      accept_cyc[i] = cycle + 1;
      issued[i]     = 1'b1;
      if (is_divide(tbl[i].op)) begin
        last_div = i;
      end
    end
    @(posedge i_clk);
    i_valid <= 1'b0;

    n = 0;
    while (returned_count() < N_ROWS && n < 2000) begin
      @(posedge i_clk);
      n++;
    end
    @(negedge i_clk);
    for (int i = 0; i < N_ROWS; i++) begin
      if (seen[i] == 0) begin
        $display("row %0d (%s) never returned a result", i, tbl[i].op.name());
        main_fail++;
      end
    end

    $display("%0d passed, %0d failed", mon_pass, mon_fail + main_fail);
    if (mon_fail + main_fail == 0 && mon_pass == N_ROWS) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

//--- sim.f
+incdir+hw
+incdir+tests
hw/muldiv_pkg.sv
hw/mul_pipe.sv
hw/div_unit.sv
hw/muldiv_pipe.sv
tests/tb_muldiv.sv

//--- run.sh
#!/bin/sh
# build and run the muldiv testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_muldiv -f sim.f --Mdir obj_dir -o tb_muldiv
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/tb_muldiv)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "Simulation PASSED"; then
  exit 0
fi
exit 1
